/* project.f */
+incdir+testbench
src/mult_pkg.sv
src/mult_int_mac.sv
src/mult_short_dp.sv
src/mulh_sequencer.sv
src/mult_top.sv
testbench/mulh_sequencer_checker.sv
testbench/tb_mult.sv

/* src/mulh_sequencer.sv */
// MULH state machine for the high word of a 32x32 product.
// Runs four 16x16 partial products through the subword datapath, one per
// cycle, and keeps the running partial sum and carry in its own registers.
// In IDLE it passes the outside subword controls through unchanged.
module mulh_sequencer import mult_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         enable_i,
  input  mult_op_e     operator_i,
  input  logic         ex_ready_i,

  // outside controls of the subword multiply
  input  shamt_t       imm_i,
  input  logic         short_subword_i,
  input  sign_sel_t    short_signed_i,

  // datapath result of the current step
  input  word_t        mac_i,
  input  logic         mac_carry_i,

  // step controls to the datapath
  output logic         step_active_o,
  output shamt_t       step_imm_o,
  output subword_sel_t step_subword_o,
  output sign_sel_t    step_signed_o,
  output logic         step_shift_arith_o,

  output word_t        acc_hi_o,
  output logic         acc_carry_o,
  output logic         multicycle_o,
  output logic         ready_o,
  output logic         mulh_done_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;

  // partial sum and its carry
  word_t acc_hi_q;
  logic  acc_carry_q;

  // register controls
  logic acc_clear;
  logic acc_load;
  logic carry_save;
  logic carry_clear;

  ////////////////////////////////////////////////////////////
  // next state and step controls
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d            = state_q;
    step_active_o      = 1'b1;
    step_imm_o         = '0;
    step_subword_o     = 2'b00;
    step_signed_o      = 2'b00;
    step_shift_arith_o = 1'b0;
    acc_clear          = 1'b0;
    acc_load           = 1'b0;
    carry_save         = 1'b0;
    carry_clear        = 1'b0;
    multicycle_o       = 1'b0;
    ready_o            = 1'b0;
    mulh_done_o        = 1'b0;

    case (state_q)
      IDLE: begin
        // pass the outside subword controls through
        step_active_o      = 1'b0;
        step_imm_o         = imm_i;
        step_subword_o     = {2{short_subword_i}};
        step_signed_o      = short_signed_i;
        // signed b without signed a never occurs, so a's bit decides
        step_shift_arith_o = short_signed_i[0];
        ready_o            = 1'b1;
        if (enable_i && (operator_i == MUL_H)) begin
          ready_o   = 1'b0;
          acc_clear = 1'b1;
          state_d   = STEP0;
        end
      end

      STEP0: begin
        // al*bl is always unsigned, keep its upper half only
        multicycle_o = 1'b1;
        step_imm_o   = MULH_SHIFT;
        acc_load     = 1'b1;
        state_d      = STEP1;
      end

      STEP1: begin
        // al*bh, signed iff b is signed
        // the 33-bit sum keeps bit 32 as its sign in the carry
        multicycle_o       = 1'b1;
        step_subword_o     = 2'b10;
        step_signed_o      = {short_signed_i[1], 1'b0};
        step_shift_arith_o = 1'b1;
        acc_load           = 1'b1;
        carry_save         = 1'b1;
        state_d            = STEP2;
      end

      STEP2: begin
        // ah*bl, signed iff a is signed
        // bits 33:32 are shifted back in, so the carry is not needed anymore
        multicycle_o       = 1'b1;
        step_subword_o     = 2'b01;
        step_signed_o      = {1'b0, short_signed_i[0]};
        step_imm_o         = MULH_SHIFT;
        step_shift_arith_o = 1'b1;
        acc_load           = 1'b1;
        carry_save         = 1'b1;
        carry_clear        = 1'b1;
        state_d            = FINISH;
      end

      FINISH: begin
        // ah*bh plus partial sum is the high word, held until taken
        step_subword_o = 2'b11;
        step_signed_o  = short_signed_i;
        ready_o        = 1'b1;
        mulh_done_o    = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and partial sum registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      acc_hi_q    <= '0;
      acc_carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (acc_clear) begin
        // fresh sequence starts from zero
        acc_hi_q    <= '0;
        acc_carry_q <= 1'b0;
      end else begin
        if (acc_load) begin
          acc_hi_q <= mac_i;
        end
        if (carry_save) begin
          acc_carry_q <= mac_carry_i & ~carry_clear;
        end
      end
    end
  end

  assign acc_hi_o    = acc_hi_q;
  assign acc_carry_o = acc_carry_q;

endmodule

/* src/mult_int_mac.sv */
// Full 32-bit integer multiply-accumulate for the MAC32 and MSU32 operators.
// Purely combinational; the result is op_c +/- op_a * op_b truncated to 32 bits.
// The top level only forwards this result for the two integer operators.
module mult_int_mac import mult_pkg::*; (
  input  word_t    op_a_i,
  input  word_t    op_b_i,
  input  word_t    op_c_i,
  input  mult_op_e operator_i,
  output word_t    result_o
);

  // msu select
  logic  is_msu;

  // a inverted for msu, otherwise passed unchanged
  word_t op_a_msu;

  // correction term, b for msu and zero otherwise
  word_t op_b_msu;

  // low word of the product
  word_t prod;

  assign is_msu = (operator_i == MUL_MSU32);

  // -a*b is computed as (~a)*b + b
  // so one multiplier serves both operators
  assign op_a_msu = op_a_i ^ {32{is_msu}};
  assign op_b_msu = op_b_i & {32{is_msu}};

  // only the low 32 bits matter, so signedness of the product is irrelevant
  assign prod = op_a_msu * op_b_i;

  // accumulate, wraps modulo 2^32
  assign result_o = op_c_i + op_b_msu + prod;

endmodule

/* src/mult_pkg.sv */
// Shared types for the 32-bit multiply unit.
// Holds the operator encoding, the MULH sequencer states and the width
// typedefs used by the datapath, the sequencer and the top level.
// Every RTL file takes it by a wildcard import in its module header.
package mult_pkg;

  ////////////////////////////////////////////////////////////
  // width typedefs
  ////////////////////////////////////////////////////////////

  // one operand or result word
  typedef logic [31:0] word_t;

  // shift immediate of the subword multiply
  typedef logic [4:0] shamt_t;

  // bit 0 marks operand a as signed, bit 1 marks operand b as signed
  typedef logic [1:0] sign_sel_t;

  // bit 0 picks the upper half of a, bit 1 the upper half of b
  typedef logic [1:0] subword_sel_t;

  // one 16-bit half of an operand
  typedef logic [15:0] half_t;

  // half plus its sign extension bit
  typedef logic [16:0] half_ext_t;

  // full 34-bit product and accumulate sum of the subword datapath
  typedef logic [33:0] mac_sum_t;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // operator select, encodings kept from the execute stage decoder
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_H     = 3'b110
  } mult_op_e;

  // MULH sequencer states, one partial product per step
  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STEP0  = 3'd1,
    STEP1  = 3'd2,
    STEP2  = 3'd3,
    FINISH = 3'd4
  } mulh_state_e;

  // shift between the low and high halves of a 32x32 product
  localparam shamt_t MULH_SHIFT = 5'd16;

endpackage

/* src/mult_short_dp.sv */
// 16x16 subword multiplier with accumulate, rounding and right shift.
// Serves MUL_I and MUL_IR directly from the outside controls, and each
// MULH step when the sequencer drives the step controls.
// The accumulator is op_c outside MULH, and the sequencer partial sum
// together with its carry inside MULH.
module mult_short_dp import mult_pkg::*; (
  input  word_t        op_a_i,
  input  word_t        op_b_i,
  input  word_t        op_c_i,
  input  mult_op_e     operator_i,

  // step controls, from the sequencer
  input  logic         step_active_i,
  input  shamt_t       step_imm_i,
  input  subword_sel_t step_subword_i,
  input  sign_sel_t    step_signed_i,
  input  logic         step_shift_arith_i,

  // partial sum of the MULH sequence
  input  word_t        acc_hi_i,
  input  logic         acc_carry_i,

  output word_t        mac_o,
  output logic         mac_carry_o
);

  ////////////////////////////////////////////////////////////
  // operand selection
  ////////////////////////////////////////////////////////////

  half_t     half_a;
  half_t     half_b;
  half_ext_t ext_a;
  half_ext_t ext_b;

  // halves picked by the subword select
  assign half_a = step_subword_i[0] ? op_a_i[31:16] : op_a_i[15:0];
  assign half_b = step_subword_i[1] ? op_b_i[31:16] : op_b_i[15:0];

  // unsigned operand gets a zero on top
  assign ext_a = {step_signed_i[0] & half_a[15], half_a};
  assign ext_b = {step_signed_i[1] & half_b[15], half_b};

  ////////////////////////////////////////////////////////////
  // multiply and accumulate
  ////////////////////////////////////////////////////////////

  mac_sum_t prod;
  mac_sum_t acc;
  mac_sum_t round_ext;
  mac_sum_t sum;
  word_t    round_tmp;
  word_t    round_val;

  // 17x17 signed product, always fits 34 bits
  assign prod = $signed(ext_a) * $signed(ext_b);

  // inside MULH the carry is the sign of a 33-bit partial sum
  // outside it, op_c is sign extended
  assign acc = step_active_i ? {acc_carry_i, acc_carry_i, acc_hi_i}
                             : {{2{op_c_i[31]}}, op_c_i};

  // rounding adds half an lsb of the shifted result
  // 1 << imm then halved, so imm of zero gives zero
  assign round_tmp = word_t'(1) << step_imm_i;
  assign round_val = (operator_i == MUL_IR) ? {1'b0, round_tmp[31:1]} : '0;
  assign round_ext = {2'b00, round_val};

  assign sum = acc + prod + round_ext;

  ////////////////////////////////////////////////////////////
  // right shift
  ////////////////////////////////////////////////////////////

  logic     fill_hi;
  logic     fill_lo;
  mac_sum_t shift_in;
  mac_sum_t shifted;

  // the two top bits decide what is shifted in
  // MULH keeps the real bits 33 and 32, the subword ops only bit 31
  assign fill_hi = step_shift_arith_i & (step_active_i ? sum[33] : sum[31]);
  assign fill_lo = step_shift_arith_i & (step_active_i ? sum[32] : sum[31]);

  assign shift_in = {fill_hi, fill_lo, sum[31:0]};
  assign shifted  = $signed(shift_in) >>> step_imm_i;

  assign mac_o = shifted[31:0];

  // carry out of the unshifted sum, saved by the sequencer in STEP1
  assign mac_carry_o = sum[32];

endmodule

/* src/mult_top.sv */
// Top level of the 32-bit multiply unit for a small RISC-V execute stage.
// Integer MAC/MSU and subword multiplies are combinational; MULH runs
// four cycles through the sequencer and holds its result until ex_ready_i.
// Operand and control inputs must stay stable until the result is used.
module mult_top import mult_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,

  input  logic      enable_i,
  input  mult_op_e  operator_i,

  // subword multiply controls
  input  logic      short_subword_i,
  input  sign_sel_t short_signed_i,

  input  word_t     op_a_i,
  input  word_t     op_b_i,
  input  word_t     op_c_i,
  input  shamt_t    imm_i,

  output word_t     result_o,
  output logic      multicycle_o,
  output logic      ready_o,
  input  logic      ex_ready_i
);

  // integer path result
  word_t int_result;

  // step controls between sequencer and datapath
  logic         step_active;
  shamt_t       step_imm;
  subword_sel_t step_subword;
  sign_sel_t    step_signed;
  logic         step_shift_arith;

  // partial sum loop
  word_t acc_hi;
  logic  acc_carry;
  word_t mac;
  logic  mac_carry;
  logic  mulh_done;

  ////////////////////////////////////////////////////////////
  // datapaths and sequencer
  ////////////////////////////////////////////////////////////

  mult_int_mac int_mac_i (
    .op_a_i     (op_a_i),
    .op_b_i     (op_b_i),
    .op_c_i     (op_c_i),
    .operator_i (operator_i),
    .result_o   (int_result)
  );

  mult_short_dp short_dp_i (
    .op_a_i             (op_a_i),
    .op_b_i             (op_b_i),
    .op_c_i             (op_c_i),
    .operator_i         (operator_i),
    .step_active_i      (step_active),
    .step_imm_i         (step_imm),
    .step_subword_i     (step_subword),
    .step_signed_i      (step_signed),
    .step_shift_arith_i (step_shift_arith),
    .acc_hi_i           (acc_hi),
    .acc_carry_i        (acc_carry),
    .mac_o              (mac),
    .mac_carry_o        (mac_carry)
  );

  mulh_sequencer mulh_seq_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .enable_i           (enable_i),
    .operator_i         (operator_i),
    .ex_ready_i         (ex_ready_i),
    .imm_i              (imm_i),
    .short_subword_i    (short_subword_i),
    .short_signed_i     (short_signed_i),
    .mac_i              (mac),
    .mac_carry_i        (mac_carry),
    .step_active_o      (step_active),
    .step_imm_o         (step_imm),
    .step_subword_o     (step_subword),
    .step_signed_o      (step_signed),
    .step_shift_arith_o (step_shift_arith),
    .acc_hi_o           (acc_hi),
    .acc_carry_o        (acc_carry),
    .multicycle_o       (multicycle_o),
    .ready_o            (ready_o),
    .mulh_done_o        (mulh_done)
  );

  ////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR:        result_o = mac;
      // intermediate partial sums are not shown
      MUL_H:                result_o = mulh_done ? mac : '0;
      default:              result_o = '0;
    endcase
  end

endmodule

/* testbench/mulh_sequencer_checker.sv */
// Concurrent assertions on the MULH sequencer FSM and its handshake.
// Attached to every mulh_sequencer instance by the bind at the end of the file.
module mulh_sequencer_checker import mult_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input mulh_state_e state_i,
  input logic        ready_i,
  input logic        multicycle_i,
  input logic        ex_ready_i
);

  // number of failed assertions, summed into the testbench result
  int failures = 0;

  // one of the three partial product steps
  logic in_step;
  assign in_step = (state_i == STEP0) || (state_i == STEP1) || (state_i == STEP2);

  // no result can be taken while partial products still run
  ready_low_in_steps: assert property (@(posedge clk) disable iff (!rst_n)
    in_step |-> !ready_i)
    else begin
      $error("ready_o high during a MULH step");
      failures++;
    end

  // multicycle flag marks exactly the step states
  multicycle_in_steps: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_i == in_step)
    else begin
      $error("multicycle_o does not match the MULH step states");
      failures++;
    end

  // steps run back to back
  step0_to_step1: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == STEP0) |=> (state_i == STEP1))
    else begin
      $error("STEP0 not followed by STEP1");
      failures++;
    end

  step1_to_step2: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == STEP1) |=> (state_i == STEP2))
    else begin
      $error("STEP1 not followed by STEP2");
      failures++;
    end

  // back-pressure keeps the result in FINISH
  finish_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == FINISH && !ex_ready_i) |=> (state_i == FINISH))
    else begin
      $error("FINISH left while ex_ready_i low");
      failures++;
    end

endmodule

bind mulh_sequencer mulh_sequencer_checker seq_checker_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .state_i      (state_q),
  .ready_i      (ready_o),
  .multicycle_i (multicycle_o),
  .ex_ready_i   (ex_ready_i)
);

/* testbench/tb_mult_model.svh */
// Reference model for the multiply unit testbench.
// Computes the expected result of every kept operator from the arithmetic
// definitions, with wide exact products truncated at the end.
// Included inside the testbench module, so it sees the package types.
`ifndef TB_MULT_MODEL_SVH
`define TB_MULT_MODEL_SVH

// op_c plus or minus a*b, modulo 2^32
function automatic word_t int_mac_result(input word_t a, input word_t b, input word_t c,
                                         input logic msu);
  logic [63:0] product;
  product = {32'd0, a} * {32'd0, b};
  if (msu) begin
    return c - product[31:0];
  end else begin
    return c + product[31:0];
  end
endfunction

// 16x16 product of the selected halves plus op_c, optional rounding, then shift
// arithmetic shift when operand a is signed
function automatic word_t subword_mul_result(input word_t a, input word_t b, input word_t c,
                                             input logic upper, input sign_sel_t sgn,
                                             input shamt_t imm, input logic round);
  logic [15:0] half_a;
  logic [15:0] half_b;
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic [63:0] total;
  word_t       low;
  half_a = upper ? a[31:16] : a[15:0];
  half_b = upper ? b[31:16] : b[15:0];
  ext_a  = sgn[0] ? {{48{half_a[15]}}, half_a} : {48'd0, half_a};
  ext_b  = sgn[1] ? {{48{half_b[15]}}, half_b} : {48'd0, half_b};
  total  = ext_a * ext_b + {32'd0, c};
  // half an lsb of the shifted result, nothing for imm of zero
  if (round && (imm != 5'd0)) begin
    total = total + (64'd1 << (imm - 5'd1));
  end
  low = total[31:0];
  if (sgn[0]) begin
    return $signed(low) >>> imm;
  end else begin
    return low >> imm;
  end
endfunction

// upper word of the exact 64-bit product
function automatic word_t mulh_high_word(input word_t a, input word_t b, input sign_sel_t sgn);
  logic [63:0] ext_a;
  logic [63:0] ext_b;
  logic [63:0] product;
  ext_a   = sgn[0] ? {{32{a[31]}}, a} : {32'd0, a};
  ext_b   = sgn[1] ? {{32{b[31]}}, b} : {32'd0, b};
  product = ext_a * ext_b;
  return product[63:32];
endfunction

`endif

/* testbench/tb_mult.sv */
// Self-checking testbench for the 32-bit multiply unit.
// Drives random operands from a fixed-seed LCG on the rising edge, checks
// every result mid-cycle against the model header and prints a summary.
module tb_mult import mult_pkg::*; ();

  localparam logic [31:0] SEED = 32'h504d8a46;
  localparam int N_MAC   = 200;
  localparam int N_SUB   = 200;
  localparam int N_MULH  = 100;
  localparam int N_BP    = 100;
  localparam int N_NO_EN = 8;
  localparam int TOTAL_TESTS = N_MAC + N_SUB + 3 * N_MULH + N_BP + N_NO_EN;
  // 8 cycles of 4 time units per test, plus reset and slack
  localparam int TIMEOUT = TOTAL_TESTS * 8 * 4 + 200;

  logic      clk;
  logic      rst_n;
  logic      enable;
  logic      subword;
  logic      ex_ready;
  mult_op_e  mul_op;
  sign_sel_t sgn;
  word_t     op_a;
  word_t     op_b;
  word_t     op_c;
  shamt_t    imm;
  word_t     result;
  logic      multicycle;
  logic      ready;

  int          errors;
  int          checks;
  logic [31:0] lcg_state;

  `include "tb_mult_model.svh"

  mult_top dut_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .enable_i        (enable),
    .operator_i      (mul_op),
    .short_subword_i (subword),
    .short_signed_i  (sgn),
    .op_a_i          (op_a),
    .op_b_i          (op_b),
    .op_c_i          (op_c),
    .imm_i           (imm),
    .result_o        (result),
    .multicycle_o    (multicycle),
    .ready_o         (ready),
    .ex_ready_i      (ex_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks and random numbers
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s expected %b actual %b", name, expected, actual);
    end
  endtask

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // low lcg bits cycle fast, so only upper halves are used
  function automatic word_t random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_random();
    lo = next_random();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic int random_below(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[31:16]) % n;
  endfunction

  // signedness modes 11, 01, 00
  function automatic sign_sel_t mode_from_index(input int idx);
    case (idx)
      0:       return 2'b11;
      1:       return 2'b01;
      default: return 2'b00;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // test sequences
  ////////////////////////////////////////////////////////////

  task automatic int_mac_sweep();
    word_t a;
    word_t b;
    word_t c;
    logic  msu;
    for (int i = 0; i < N_MAC; i++) begin
      a   = random_word();
      b   = random_word();
      c   = random_word();
      msu = (random_below(2) == 1);
      @(posedge clk);
      op_a   <= a;
      op_b   <= b;
      op_c   <= c;
      mul_op <= msu ? MUL_MSU32 : MUL_MAC32;
      @(negedge clk);
      check_word($sformatf("mac32 msu=%b #%0d", msu, i), int_mac_result(a, b, c, msu), result);
      check_bit("ready during mac32", 1'b1, ready);
    end
  endtask

  task automatic subword_sweep();
    word_t     a;
    word_t     b;
    word_t     c;
    logic      upper;
    logic      round;
    sign_sel_t mode;
    shamt_t    shift;
    for (int i = 0; i < N_SUB; i++) begin
      a     = random_word();
      b     = random_word();
      c     = random_word();
      upper = (random_below(2) == 1);
      round = (random_below(2) == 1);
      mode  = mode_from_index(random_below(3));
      shift = shamt_t'(random_below(32));
      @(posedge clk);
      op_a    <= a;
      op_b    <= b;
      op_c    <= c;
      subword <= upper;
      sgn     <= mode;
      imm     <= shift;
      mul_op  <= round ? MUL_IR : MUL_I;
      @(negedge clk);
      check_word($sformatf("mul_i round=%b sgn=%b imm=%0d #%0d", round, mode, shift, i),
                 subword_mul_result(a, b, c, upper, mode, shift, round), result);
      check_bit("ready during mul_i", 1'b1, ready);
    end
  endtask

  // one MULH from acceptance to the return to IDLE, FINISH held for hold extra cycles
  task automatic mulh_sequence(input word_t a, input word_t b, input sign_sel_t mode,
                               input int hold, input string tag);
    word_t expected;
    expected = mulh_high_word(a, b, mode);
    @(posedge clk);
    op_a     <= a;
    op_b     <= b;
    op_c     <= random_word();
    sgn      <= mode;
    mul_op   <= MUL_H;
    enable   <= 1'b1;
    ex_ready <= 1'b0;
    @(negedge clk);
    check_bit({tag, " ready at acceptance"}, 1'b0, ready);
    // three step edges, the first one is the acceptance edge
    for (int s = 0; s < 3; s++) begin
      @(posedge clk);
      enable <= 1'b0;
      @(negedge clk);
      check_bit($sformatf("%s multicycle step %0d", tag, s), 1'b1, multicycle);
      check_bit($sformatf("%s ready step %0d", tag, s), 1'b0, ready);
    end
    // 4th edge enters FINISH
    @(posedge clk);
    ex_ready <= (hold == 0);
    @(negedge clk);
    check_bit({tag, " ready in finish"}, 1'b1, ready);
    check_bit({tag, " multicycle in finish"}, 1'b0, multicycle);
    check_word({tag, " high word"}, expected, result);
    for (int h = 0; h < hold; h++) begin
      @(posedge clk);
      ex_ready <= (h == hold - 1);
      @(negedge clk);
      check_word($sformatf("%s held word %0d", tag, h), expected, result);
      check_bit($sformatf("%s held ready %0d", tag, h), 1'b1, ready);
    end
    // back in IDLE, the MUL_H result select shows zero
    @(posedge clk);
    @(negedge clk);
    check_bit({tag, " ready in idle"}, 1'b1, ready);
    check_bit({tag, " multicycle in idle"}, 1'b0, multicycle);
    check_word({tag, " result in idle"}, '0, result);
  endtask

  task automatic no_enable_check();
    @(posedge clk);
    enable   <= 1'b0;
    mul_op   <= MUL_H;
    ex_ready <= 1'b1;
    for (int i = 0; i < N_NO_EN; i++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("ready without enable", 1'b1, ready);
      check_bit("multicycle without enable", 1'b0, multicycle);
      check_word("mulh result without enable", '0, result);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    word_t     a;
    word_t     b;
    sign_sel_t mode;
    int        assert_failures;
    lcg_state = SEED;
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    enable    = 1'b0;
    mul_op    = MUL_MAC32;
    subword   = 1'b0;
    sgn       = '0;
    op_a      = '0;
    op_b      = '0;
    op_c      = '0;
    imm       = '0;
    ex_ready  = 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("ready after reset", 1'b1, ready);
    check_bit("multicycle after reset", 1'b0, multicycle);

    int_mac_sweep();
    subword_sweep();

    for (int m = 0; m < 3; m++) begin
      mode = mode_from_index(m);
      for (int i = 0; i < N_MULH; i++) begin
        a = random_word();
        b = random_word();
        // most negative and all-ones operands first
        if (i == 0) begin
          a = 32'h8000_0000;
          b = 32'h8000_0000;
        end else if (i == 1) begin
          a = 32'hffff_ffff;
          b = 32'hffff_ffff;
        end
        mulh_sequence(a, b, mode, 0, $sformatf("mulh sgn=%b #%0d", mode, i));
      end
    end

    for (int i = 0; i < N_BP; i++) begin
      mode = mode_from_index(random_below(3));
      mulh_sequence(random_word(), random_word(), mode, random_below(6),
                    $sformatf("mulh stall sgn=%b #%0d", mode, i));
    end

    no_enable_check();

    // failed sequencer assertions count as errors too
    assert_failures = dut_i.mulh_seq_i.seq_checker_i.failures;
    $display("tb_mult: %0d errors in %0d checks, %0d assertion failures",
             errors, checks, assert_failures);
    if (errors == 0 && assert_failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog: tests did not finish within %0d time units", TIMEOUT);
    $display("Test failures found");
    $finish;
  end

endmodule
